// ==== rtl/axiw_cfg.svh ====
`ifndef AXIW_CFG_SVH
`define AXIW_CFG_SVH

// Byte address and AXI data bus
`define AXIW_ADDR_W 32
`define AXIW_DATA_W 32

// Byte lanes per beat and the offset bits inside one beat
`define AXIW_STRB_W (`AXIW_DATA_W / 8)
`define AXIW_OFF_W ($clog2(`AXIW_STRB_W))

// Transfer length in bytes on the simple port
`define AXIW_LEN_W 16

// AXI4 awlen field
`define AXIW_BURST_W 8

// Beats per burst until software changes it
`define AXIW_MAX_BURST_RST 16

`endif

// ==== rtl/axiw_pkg.sv ====
`default_nettype none
`include "axiw_cfg.svh"

package axiw_pkg;

   typedef struct packed {
      logic [`AXIW_ADDR_W-1:0] addr;
      logic [`AXIW_LEN_W-1:0]  len;   // Bytes
   } simple_req_t;

   typedef struct packed {
      logic [`AXIW_DATA_W-1:0] data;
      logic                    last;
   } simple_data_t;

   typedef struct packed {
      logic [`AXIW_ADDR_W-1:0]  addr;
      logic [`AXIW_BURST_W-1:0] len;
      logic [2:0]               size;
      logic [1:0]               burst;
   } axi_aw_t;

   typedef struct packed {
      logic [`AXIW_DATA_W-1:0] data;
      logic [`AXIW_STRB_W-1:0] strb;
      logic                    last;
   } axi_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } axi_b_t;

   // One burst as issued on AW, plus what the W side needs
   typedef struct packed {
      logic [`AXIW_ADDR_W-1:0]  addr;
      logic [`AXIW_BURST_W-1:0] beats_minus_one;
      logic [`AXIW_STRB_W-1:0]  first_strb;
      logic [`AXIW_STRB_W-1:0]  last_strb;
      logic                     last_burst;
      logic                     extra_beat;   // Realigned data needs one more beat than source
   } burst_plan_t;

   typedef struct packed {
      logic        we;
      logic [3:0]  addr;
      logic [31:0] wdata;
   } reg_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/axiw_burst_planner.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_burst_planner (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   start_i,
   input  axiw_pkg::simple_req_t  req_i,
   input  logic                   next_burst_i,
   input  logic [8:0]             max_beats_i,
   output axiw_pkg::burst_plan_t  plan_o,
   output logic [`AXIW_LEN_W-1:0] src_words_o
);

   localparam int CNT_W      = `AXIW_LEN_W + 1;
   localparam int BURST_W    = `AXIW_BURST_W;
   localparam int STRB_W     = `AXIW_STRB_W;
   localparam int OFF_W      = `AXIW_OFF_W;
   localparam int PAGE_BEATS = 4096 / STRB_W;

   logic [OFF_W-1:0]        req_off;
   logic [OFF_W-1:0]        end_off;
   logic [CNT_W-1:0]        req_bytes;
   logic [CNT_W-1:0]        req_beats;
   logic [`AXIW_LEN_W-1:0]  req_words;
   logic [STRB_W-1:0]       first_strb;
   logic [STRB_W-1:0]       last_strb;
   logic [`AXIW_ADDR_W-1:0] next_addr_q;
   logic [CNT_W-1:0]        rem_beats_q;   // Beats still to plan after current burst
   logic [`AXIW_ADDR_W-1:0] base_addr;
   logic [CNT_W-1:0]        base_rem;
   logic [CNT_W-1:0]        to_4k;
   logic [CNT_W-1:0]        beats;

   assign req_off   = req_i.addr[OFF_W-1:0];
   assign req_bytes = CNT_W'(req_i.len) + CNT_W'(req_off);
   assign req_beats = (req_bytes + CNT_W'(STRB_W - 1)) >> OFF_W;
   assign req_words = `AXIW_LEN_W'((CNT_W'(req_i.len) + CNT_W'(STRB_W - 1)) >> OFF_W);
   assign end_off   = req_bytes[OFF_W-1:0];

   assign first_strb = {STRB_W{1'b1}} << req_off;
   assign last_strb  = (end_off == '0) ? {STRB_W{1'b1}} : ~({STRB_W{1'b1}} << end_off);

   // Bursts after the first start on a beat boundary
   assign base_addr = start_i ? {req_i.addr[`AXIW_ADDR_W-1:OFF_W], {OFF_W{1'b0}}} : next_addr_q;
   assign base_rem  = start_i ? req_beats : rem_beats_q;
   assign to_4k     = CNT_W'(PAGE_BEATS) - CNT_W'(base_addr[11:OFF_W]);

   always_comb begin
      beats = CNT_W'(max_beats_i);
      if (to_4k < beats)
         beats = to_4k;
      if (base_rem < beats)
         beats = base_rem;
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         plan_o      <= '0;
         next_addr_q <= '0;
         rem_beats_q <= '0;
         src_words_o <= '0;
      end else if (start_i || next_burst_i) begin
         plan_o.addr            <= base_addr;
         plan_o.beats_minus_one <= BURST_W'(beats - CNT_W'(1));
         plan_o.last_burst      <= (beats == base_rem);
         next_addr_q            <= base_addr + (`AXIW_ADDR_W'(beats) << OFF_W);
         rem_beats_q            <= base_rem - beats;
         if (start_i) begin   // Per-transfer fields
            plan_o.first_strb <= first_strb;
            plan_o.last_strb  <= last_strb;
            plan_o.extra_beat <= (req_beats > CNT_W'(req_words));
            src_words_o       <= req_words;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/axiw_realign.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_realign (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic [`AXIW_OFF_W-1:0]  offset_i,
   input  logic                    flush_i,
   input  logic [`AXIW_DATA_W-1:0] in_i,
   input  logic                    in_valid_i,
   output logic [`AXIW_DATA_W-1:0] out_o
);

   logic [`AXIW_DATA_W-1:0]   carry_q;   // Upper bytes that spilled out of the last word
   logic [2*`AXIW_DATA_W-1:0] shifted;

   // Low half goes out now, high half waits for the next beat
   assign shifted = {{`AXIW_DATA_W{1'b0}}, in_i} << {offset_i, 3'b000};

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         carry_q <= '0;
      end else if (flush_i) begin
         carry_q <= '0;
      end else if (in_valid_i) begin
         carry_q <= shifted[2*`AXIW_DATA_W-1:`AXIW_DATA_W];
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_valid_i)
         out_o <= shifted[`AXIW_DATA_W-1:0] | carry_q;
   end

endmodule

`default_nettype wire

// ==== rtl/axiw_write_bridge.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_write_bridge (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axiw_pkg::simple_req_t   req_i,
   input  logic                    req_valid_i,
   output logic                    req_ready_o,
   input  axiw_pkg::simple_data_t  data_i,
   input  logic                    data_valid_i,
   output logic                    data_ready_o,
   input  axiw_pkg::burst_plan_t   plan_i,
   input  logic [`AXIW_LEN_W-1:0]  src_words_i,
   input  logic [`AXIW_DATA_W-1:0] aligned_i,
   output logic                    start_o,
   output logic                    next_burst_o,
   output logic [`AXIW_OFF_W-1:0]  offset_o,
   output logic                    flush_o,
   output logic                    shift_o,
   output axiw_pkg::axi_aw_t       aw_o,
   output logic                    aw_valid_o,
   input  logic                    aw_ready_i,
   output axiw_pkg::axi_w_t        w_o,
   output logic                    w_valid_o,
   input  logic                    w_ready_i,
   output logic                    busy_o,
   output logic                    done_o
);

   localparam int CNT_W = `AXIW_BURST_W + 1;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PLAN,
      ST_ADDR,
      ST_DATA
   } state_t;

   state_t                  state_q;
   logic                    aw_valid_q;
   logic                    w_valid_q;   // Realigner output holds a beat
   logic [`AXIW_STRB_W-1:0] w_strb_q;
   logic                    w_last_q;
   logic [CNT_W-1:0]        issue_cnt_q;
   logic                    first_q;
   logic [`AXIW_LEN_W-1:0]  src_cnt_q;
   logic                    src_done_q;
   logic [`AXIW_OFF_W-1:0]  offset_q;
   logic                    w_hs;
   logic                    issue_all;
   logic                    can_load;
   logic                    beat_last;
   logic                    burst_end;
   logic [`AXIW_STRB_W-1:0] beat_strb;

   assign req_ready_o = (state_q == ST_IDLE) && req_valid_i;
   assign start_o     = req_ready_o;
   assign flush_o     = req_ready_o;
   assign offset_o    = offset_q;

   assign w_hs      = w_valid_q && w_ready_i;
   assign issue_all = issue_cnt_q > {1'b0, plan_i.beats_minus_one};
   assign beat_last = issue_cnt_q[CNT_W-2:0] == plan_i.beats_minus_one;
   assign burst_end = (state_q == ST_DATA) && w_hs && w_last_q;

   // First beat may load on the AW handshake itself
   assign can_load = ((state_q == ST_DATA) || ((state_q == ST_ADDR) && aw_ready_i)) &&
                     !issue_all && (!w_valid_q || w_ready_i);

   assign data_ready_o = can_load && !src_done_q;
   assign shift_o      = can_load && (src_done_q ? plan_i.extra_beat : data_valid_i);   // Source gone means extra beat

   always_comb begin
      beat_strb = '1;
      if (first_q)
         beat_strb = plan_i.first_strb;
      if (plan_i.last_burst && beat_last)
         beat_strb = beat_strb & plan_i.last_strb;
   end

   assign aw_o.addr  = plan_i.addr;
   assign aw_o.len   = plan_i.beats_minus_one;
   assign aw_o.size  = 3'(`AXIW_OFF_W);
   assign aw_o.burst = 2'b01;   // INCR
   assign aw_valid_o = aw_valid_q;

   assign w_o.data  = aligned_i;
   assign w_o.strb  = w_strb_q;
   assign w_o.last  = w_last_q;
   assign w_valid_o = w_valid_q;

   assign next_burst_o = burst_end && !plan_i.last_burst;
   assign done_o       = burst_end && plan_i.last_burst;
   assign busy_o       = state_q != ST_IDLE;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         aw_valid_q  <= 1'b0;
         issue_cnt_q <= '0;
         first_q     <= 1'b0;
         offset_q    <= '0;
      end else begin
         if (shift_o) begin
            issue_cnt_q <= issue_cnt_q + CNT_W'(1);
            first_q     <= 1'b0;
         end
         case (state_q)
            ST_IDLE: begin
               if (req_ready_o) begin
                  offset_q <= req_i.addr[`AXIW_OFF_W-1:0];
                  first_q  <= 1'b1;
                  state_q  <= ST_PLAN;
               end
            end
            ST_PLAN: begin   // Planner output settles here
               aw_valid_q  <= 1'b1;
               issue_cnt_q <= '0;
               state_q     <= ST_ADDR;
            end
            ST_ADDR: begin
               if (aw_ready_i) begin
                  aw_valid_q <= 1'b0;
                  state_q    <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (done_o) begin
                  state_q <= ST_IDLE;
               end else if (next_burst_o) begin
                  aw_valid_q  <= 1'b1;
                  issue_cnt_q <= '0;
                  state_q     <= ST_ADDR;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Source word accounting
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         src_cnt_q  <= '0;
         src_done_q <= 1'b0;
      end else if (start_o) begin
         src_cnt_q  <= '0;
         src_done_q <= 1'b0;
      end else if (data_valid_i && data_ready_o) begin
         src_cnt_q <= src_cnt_q + 1'b1;
         if (data_i.last || (src_cnt_q + 1'b1 == src_words_i))
            src_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         w_valid_q <= 1'b0;
      end else if (shift_o) begin
         w_valid_q <= 1'b1;
      end else if (w_hs) begin
         w_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (shift_o) begin
         w_strb_q <= beat_strb;
         w_last_q <= beat_last;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/axiw_regs.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_regs (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  axiw_pkg::reg_cmd_t   reg_cmd_i,
   input  logic [3:0]           reg_raddr_i,
   output logic [31:0]          reg_rdata_o,
   input  axiw_pkg::axi_b_t     b_i,
   input  logic                 b_valid_i,
   input  logic                 busy_i,
   output logic [8:0]           max_beats_o
);

   logic [31:0] okay_cnt_q;
   logic [31:0] err_cnt_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         max_beats_o <= 9'(`AXIW_MAX_BURST_RST);
      end else if (reg_cmd_i.we && (reg_cmd_i.addr == 4'd0)) begin
         if (reg_cmd_i.wdata == 32'd0)
            max_beats_o <= 9'd1;
         else if (reg_cmd_i.wdata > 32'd256)
            max_beats_o <= 9'd256;   // AXI4 INCR limit
         else
            max_beats_o <= reg_cmd_i.wdata[8:0];
      end
   end

   // B is always accepted, so every valid is one response
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         okay_cnt_q <= '0;
         err_cnt_q  <= '0;
      end else if (b_valid_i) begin
         if (b_i.resp[1]) begin   // SLVERR or DECERR
            if (err_cnt_q != '1)
               err_cnt_q <= err_cnt_q + 1'b1;
         end else if (okay_cnt_q != '1) begin
            okay_cnt_q <= okay_cnt_q + 1'b1;
         end
      end
   end

   always_comb begin
      case (reg_raddr_i)
         4'd0:    reg_rdata_o = {23'd0, max_beats_o};
         4'd1:    reg_rdata_o = okay_cnt_q;
         4'd2:    reg_rdata_o = err_cnt_q;
         4'd3:    reg_rdata_o = {31'd0, busy_i};
         default: reg_rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/axiw_top.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  axiw_pkg::simple_req_t  req_i,
   input  logic                   req_valid_i,
   output logic                   req_ready_o,
   input  axiw_pkg::simple_data_t data_i,
   input  logic                   data_valid_i,
   output logic                   data_ready_o,
   output axiw_pkg::axi_aw_t      aw_o,
   output logic                   aw_valid_o,
   input  logic                   aw_ready_i,
   output axiw_pkg::axi_w_t       w_o,
   output logic                   w_valid_o,
   input  logic                   w_ready_i,
   input  axiw_pkg::axi_b_t       b_i,
   input  logic                   b_valid_i,   // bready is tied high
   input  axiw_pkg::reg_cmd_t     reg_cmd_i,
   input  logic [3:0]             reg_raddr_i,
   output logic [31:0]            reg_rdata_o,
   output logic                   done_o
);

   axiw_pkg::burst_plan_t   plan;
   logic [`AXIW_LEN_W-1:0]  src_words;
   logic [`AXIW_DATA_W-1:0] aligned;
   logic [`AXIW_OFF_W-1:0]  offset;
   logic [8:0]              max_beats;
   logic                    start;
   logic                    next_burst;
   logic                    flush;
   logic                    shift;
   logic                    busy;

   axiw_regs axiw_regs_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .reg_cmd_i   (reg_cmd_i),
      .reg_raddr_i (reg_raddr_i),
      .reg_rdata_o (reg_rdata_o),
      .b_i         (b_i),
      .b_valid_i   (b_valid_i),
      .busy_i      (busy),
      .max_beats_o (max_beats)
   );

   axiw_write_bridge axiw_write_bridge_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (req_i),
      .req_valid_i  (req_valid_i),
      .req_ready_o  (req_ready_o),
      .data_i       (data_i),
      .data_valid_i (data_valid_i),
      .data_ready_o (data_ready_o),
      .plan_i       (plan),
      .src_words_i  (src_words),
      .aligned_i    (aligned),
      .start_o      (start),
      .next_burst_o (next_burst),
      .offset_o     (offset),
      .flush_o      (flush),
      .shift_o      (shift),
      .aw_o         (aw_o),
      .aw_valid_o   (aw_valid_o),
      .aw_ready_i   (aw_ready_i),
      .w_o          (w_o),
      .w_valid_o    (w_valid_o),
      .w_ready_i    (w_ready_i),
      .busy_o       (busy),
      .done_o       (done_o)
   );

   axiw_burst_planner axiw_burst_planner_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start),
      .req_i        (req_i),
      .next_burst_i (next_burst),
      .max_beats_i  (max_beats),
      .plan_o       (plan),
      .src_words_o  (src_words)
   );

   axiw_realign axiw_realign_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .offset_i   (offset),
      .flush_i    (flush),
      .in_i       (data_i.data),
      .in_valid_i (shift),
      .out_o      (aligned)
   );

endmodule

`default_nettype wire

// ==== bench/axiw_assertions.sv ====
`default_nettype none

module axiw_assertions (
   input logic              clk_i,
   input logic              rst_i,
   input axiw_pkg::axi_aw_t aw_i,
   input logic              aw_valid_i,
   input logic              aw_ready_i,
   input axiw_pkg::axi_w_t  w_i,
   input logic              w_valid_i,
   input logic              w_ready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
      else $error("AW valid dropped or AW payload changed before ready");

   w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
      else $error("W valid dropped or W payload changed before ready");

   aw_incr: assert property (@(posedge clk_i) disable iff (rst_i)
      aw_valid_i |-> aw_i.burst == 2'b01)
      else $error("AW burst type is not INCR");

   // Last beat of the burst stays inside the 4 KB page
   aw_page: assert property (@(posedge clk_i) disable iff (rst_i)
      aw_valid_i |-> ({1'b0, aw_i.addr[11:2]} + 11'(aw_i.len)) < 11'd1024)
      else $error("AW burst crosses a 4 KB boundary");

endmodule

bind axiw_top axiw_assertions axiw_assertions_inst (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .aw_i       (aw_o),
   .aw_valid_i (aw_valid_o),
   .aw_ready_i (aw_ready_i),
   .w_i        (w_o),
   .w_valid_i  (w_valid_o),
   .w_ready_i  (w_ready_i)
);

`default_nettype wire

// ==== bench/axiw_tb.sv ====
`default_nettype none
`include "axiw_cfg.svh"

module axiw_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_LINES = 32;
   localparam int MEM_BYTES = 16384;

   logic                   clk_i = 1'b0;
   logic                   rst_i;
   axiw_pkg::simple_req_t  req_i;
   logic                   req_valid_i;
   logic                   req_ready_o;
   axiw_pkg::simple_data_t data_i;
   logic                   data_valid_i;
   logic                   data_ready_o;
   axiw_pkg::axi_aw_t      aw_o;
   logic                   aw_valid_o;
   logic                   aw_ready_i;
   axiw_pkg::axi_w_t       w_o;
   logic                   w_valid_o;
   logic                   w_ready_i;
   axiw_pkg::axi_b_t       b_i;
   logic                   b_valid_i;
   axiw_pkg::reg_cmd_t     reg_cmd_i;
   logic [3:0]             reg_raddr_i;
   logic [31:0]            reg_rdata_o;
   logic                   done_o;

   logic [31:0]            vec [0:5*MAX_LINES-1];   // Five columns per transfer
   logic [7:0]             mem [0:MEM_BYTES-1];
   logic [7:0]             ref_mem [0:MEM_BYTES-1];
   logic [31:0]            words [$];
   logic [31:0]            aw_addr_q [$];   // Bursts waiting for W beats
   logic [7:0]             aw_len_q [$];
   logic [1:0]             b_q [$];
   logic [31:0]            rng = 32'h7b56d5f3;
   axiw_pkg::reg_cmd_t     reg_cmd_next;
   axiw_pkg::simple_req_t  req_next;
   logic [3:0]             raddr_next;
   logic [31:0]            rdata_smp;
   logic [31:0]            next_aw_addr;
   logic [1:0]             cur_bresp;
   int                     cur_max;
   int                     word_idx;
   int                     beat_cnt;
   bit                     req_pend;
   bit                     done_seen;
   int                     okay_exp;
   int                     err_exp;
   int                     cycle_cnt = 0;
   int                     cycle_limit = 0;

   axiw_top axiw_top_inst (.*);

   always #10 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Every address bit takes part
   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
   endfunction

   task automatic stop_with(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   task automatic mismatch(input string msg);
      stop_with($sformatf("Mismatch at time %0t: %s", $time, msg));
   endtask

   task automatic check_aw();
      logic [31:0] last_byte;
      last_byte = aw_o.addr + (aw_o.len + 1) * 4 - 1;
      assert (aw_o.addr == next_aw_addr)
         else mismatch($sformatf("AW addr %08h, expected %08h", aw_o.addr, next_aw_addr));
      assert (aw_o.size == 3'd2)
         else mismatch($sformatf("awsize %0d, expected 2 for 4-byte beats", aw_o.size));
      assert (aw_o.addr[31:12] == last_byte[31:12])
         else mismatch($sformatf("burst %08h..%08h crosses 4 KB", aw_o.addr, last_byte));
      assert (int'(aw_o.len) + 1 <= cur_max)
         else mismatch($sformatf("awlen %0d exceeds max burst %0d", aw_o.len, cur_max));
      assert (last_byte < MEM_BYTES)
         else stop_with("Burst runs past the end of the slave memory");
      next_aw_addr = last_byte + 1;
      aw_addr_q.push_back(aw_o.addr);
      aw_len_q.push_back(aw_o.len);
   endtask

   task automatic take_beat();
      logic [31:0] base;
      int          i;
      if (aw_len_q.size() == 0) begin
         stop_with("W beat arrived with no open AW burst");
      end else begin
         base = aw_addr_q[0] + beat_cnt * 4;
         assert (w_o.last == (beat_cnt == aw_len_q[0]))
            else mismatch($sformatf("wlast %0b on beat %0d of awlen %0d",
                                    w_o.last, beat_cnt, aw_len_q[0]));
         for (i = 0; i < 4; i++)
            if (w_o.strb[i])
               mem[base + i] = w_o.data[8*i +: 8];
         if (beat_cnt == aw_len_q[0]) begin
            void'(aw_addr_q.pop_front());
            void'(aw_len_q.pop_front());
            beat_cnt = 0;
            b_q.push_back(cur_bresp);
            if (cur_bresp[1])   // SLVERR or DECERR
               err_exp++;
            else
               okay_exp++;
         end else begin
            beat_cnt++;
         end
      end
   endtask

   // Drive on the falling edge and sample in the low phase
   task automatic cycle();
      @(negedge clk_i);
      rng          = lcg_step(rng);
      w_ready_i    = rng[31:30] != 2'b00;
      aw_ready_i   = rng[29];
      reg_cmd_i    = reg_cmd_next;
      reg_cmd_next = '0;
      reg_raddr_i  = raddr_next;
      req_i        = req_next;
      req_valid_i  = req_pend;
      data_valid_i = !req_pend && (word_idx < words.size());
      if (data_valid_i) begin
         data_i.data = words[word_idx];
         data_i.last = (word_idx == words.size() - 1);
      end
      b_valid_i = b_q.size() > 0;
      if (b_valid_i)
         b_i.resp = b_q.pop_front();
      #5;
      rdata_smp = reg_rdata_o;
      if (req_valid_i && req_ready_o)
         req_pend = 1'b0;
      if (data_valid_i && data_ready_o)
         word_idx++;
      if (aw_valid_o && aw_ready_i)
         check_aw();
      if (w_valid_o && w_ready_i)
         take_beat();
      if (done_o) begin
         assert (w_valid_o && w_ready_i && w_o.last && (aw_len_q.size() == 0))
            else mismatch("done_o high without the final wlast handshake");
         done_seen = 1'b1;
      end
   endtask

   task automatic check_memory();
      int a;
      for (a = 0; a < MEM_BYTES; a++)
         assert (mem[a] === ref_mem[a])
            else mismatch($sformatf("byte %04h is %02h, expected %02h", a, mem[a], ref_mem[a]));
   endtask

   task automatic run_transfer(input int n);
      logic [31:0] addr;
      logic [31:0] s;
      logic [31:0] wd;
      logic [31:0] end_addr;
      int          len;
      int          k;
      addr      = vec[5*n];
      len       = vec[5*n+1];
      s         = vec[5*n+2];
      cur_bresp = vec[5*n+3][1:0];
      cur_max   = vec[5*n+4];
      if (vec[5*n+4] == 0)
         cur_max = 1;
      else if (vec[5*n+4] > 256)
         cur_max = 256;
      reg_cmd_next.we    = 1'b1;
      reg_cmd_next.addr  = 4'd0;
      reg_cmd_next.wdata = vec[5*n+4];
      cycle();
      raddr_next = 4'd0;
      cycle();
      assert (rdata_smp == cur_max)
         else mismatch($sformatf("max burst reads %0d, expected %0d", rdata_smp, cur_max));
      // Byte 0 of the stream sits in lane 0 of the first word
      words.delete();
      wd = '0;
      for (k = 0; k < len; k++) begin
         s = lcg_step(s);
         wd[8*(k%4) +: 8] = s[23:16];
         ref_mem[addr + k] = s[23:16];
         if ((k % 4 == 3) || (k == len - 1)) begin
            words.push_back(wd);
            wd = '0;
         end
      end
      word_idx      = 0;
      beat_cnt      = 0;
      next_aw_addr  = {addr[31:2], 2'b00};
      end_addr      = next_aw_addr + 4 * ((len + addr[1:0] + 3) / 4);
      req_next.addr = addr;
      req_next.len  = 16'(len);
      req_pend      = 1'b1;
      done_seen     = 1'b0;
      while (!done_seen)
         cycle();
      check_memory();
      assert (next_aw_addr == end_addr)
         else mismatch($sformatf("bursts end at %08h, expected %08h", next_aw_addr, end_addr));
      assert (!req_pend && (word_idx == words.size()) && (aw_len_q.size() == 0))
         else stop_with("Transfer finished with source words or bursts left over");
   endtask

   always @(posedge clk_i) begin
      cycle_cnt++;
      if ((cycle_limit > 0) && (cycle_cnt > cycle_limit))
         stop_with($sformatf("Timeout: run exceeded %0d clock cycles", cycle_limit));
   end

   initial begin
      int n;
      int lines;
      rst_i        = 1'b1;
      req_i        = '0;
      req_valid_i  = 1'b0;
      data_i       = '0;
      data_valid_i = 1'b0;
      aw_ready_i   = 1'b0;
      w_ready_i    = 1'b0;
      b_i          = '0;
      b_valid_i    = 1'b0;
      reg_cmd_i    = '0;
      reg_raddr_i  = '0;
      reg_cmd_next = '0;
      req_next     = '0;
      raddr_next   = '0;
      req_pend     = 1'b0;
      done_seen    = 1'b0;
      word_idx     = 0;
      beat_cnt     = 0;
      okay_exp     = 0;
      err_exp      = 0;
      for (n = 0; n < 5 * MAX_LINES; n++)
         vec[n] = '0;
      $readmemh("bench/axiw_testdata.txt", vec);
      lines = 0;
      while ((lines < MAX_LINES) && (vec[5*lines+1] != 0))
         lines++;
      if (lines == 0)
         stop_with("No transfers found in the test data file");
      cycle_limit = 200 * lines + 50;
      for (n = 0; n < MEM_BYTES; n++) begin
         mem[n]     = fill_byte(n);
         ref_mem[n] = fill_byte(n);
      end
      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      for (n = 0; n < lines; n++)
         run_transfer(n);
      while (b_q.size() > 0)
         cycle();
      raddr_next = 4'd1;
      cycle();
      assert (rdata_smp == okay_exp)
         else mismatch($sformatf("OKAY count %0d, expected %0d", rdata_smp, okay_exp));
      raddr_next = 4'd2;
      cycle();
      assert (rdata_smp == err_exp)
         else mismatch($sformatf("error count %0d, expected %0d", rdata_smp, err_exp));
      raddr_next = 4'd3;
      cycle();
      assert (rdata_smp == 0)
         else mismatch($sformatf("busy reads %0d after the last transfer", rdata_smp));
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/axiw_testdata.txt ====
// addr     len      seed     bresp max_burst   (all hex, one transfer per line)
// bresp 0 OKAY, 2 SLVERR, 3 DECERR; max_burst 0 or above 100 gets clamped
00000100 00000040 12345678 0 10
00000201 00000023 0badf00d 0 4
00000302 0000001f 5eed0001 2 8
00000403 0000000e 5eed0002 0 3
00000ff2 00000030 5eed0003 3 100
00001ffd 00000009 5eed0004 0 1
00002003 00000002 5eed0005 2 2
00002100 00000001 5eed0006 0 10
00002abe 00000051 5eed0007 0 12c
00003ff9 00000007 5eed0008 3 0
00000600 00000080 5eed0009 0 20
00000701 00000005 5eed000a 0 2

// ==== tb.f ====
+incdir+rtl
rtl/axiw_pkg.sv
rtl/axiw_burst_planner.sv
rtl/axiw_realign.sv
rtl/axiw_write_bridge.sv
rtl/axiw_regs.sv
rtl/axiw_top.sv
bench/axiw_assertions.sv
bench/axiw_tb.sv

// ==== Bender.yml ====
package:
  name: axiw_bridge

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/axiw_pkg.sv
      - rtl/axiw_burst_planner.sv
      - rtl/axiw_realign.sv
      - rtl/axiw_write_bridge.sv
      - rtl/axiw_regs.sv
      - rtl/axiw_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/axiw_assertions.sv
      - bench/axiw_tb.sv
